//--- Makefile
TOP = tb_mrnw_core

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only +incdir+hw hw/mrnw_pkg.sv hw/sram_multi_read.sv \
	  hw/map_table.sv hw/req_pipe.sv hw/bank_mapper.sv hw/bank_array.sv \
	  hw/mrnw_core.sv --top-module mrnw_core
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- build.f
+incdir+hw
hw/mrnw_pkg.sv
hw/sram_multi_read.sv
hw/map_table.sv
hw/req_pipe.sv
hw/bank_mapper.sv
hw/bank_array.sv
hw/mrnw_core.sv
testbench/tb_mrnw_core.sv

//--- hw/bank_array.sv
`timescale 1ns/1ps
`include "mrnw_config.svh"
`default_nettype none

module bank_array (
  input  logic              clk,
  input  logic              rst,
  input  logic              pw0_en,
  input  logic              pw1_en,
  input  mrnw_pkg::pbank_t  pw0_bank,
  input  mrnw_pkg::pbank_t  pw1_bank,
  input  mrnw_pkg::vrow_t   s1_wr0_row,
  input  mrnw_pkg::vrow_t   s1_wr1_row,
  input  mrnw_pkg::data_t   s1_wr0_data,
  input  mrnw_pkg::data_t   s1_wr1_data,
  input  logic              s1_rd_en,
  input  mrnw_pkg::pbank_t  pr_bank,
  input  mrnw_pkg::vrow_t   s1_rd_row,
  output logic              rd_vld,
  output mrnw_pkg::data_t   rd_data
);

  mrnw_pkg::data_t [`MRNW_NUM_PBNK-1:0] bank_rd;
  mrnw_pkg::pbank_t                     rd_bank_q;

  for (genvar b = 0; b < `MRNW_NUM_PBNK; b++) begin : g_bank
    logic hit0;
    logic hit1;

    assign hit0 = pw0_en && (pw0_bank == mrnw_pkg::pbank_t'(b));
    assign hit1 = pw1_en && (pw1_bank == mrnw_pkg::pbank_t'(b));

    // every bank reads the read row, the output mux picks one
    sram_multi_read #(
      .word_t (mrnw_pkg::data_t),
      .DEPTH  (`MRNW_NUM_VROW),
      .NUM_RD (1)
    ) u_bank_mem (
      .clk   (clk),
      .we    (hit0 || hit1),
      .waddr (hit1 ? s1_wr1_row : s1_wr0_row),
      .wdata (hit1 ? s1_wr1_data : s1_wr0_data),
      .raddr (s1_rd_row),
      .rdata (bank_rd[b])
    );
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= s1_rd_en;
    end
  end

  always_ff @(posedge clk) begin
    rd_bank_q <= pr_bank;
  end

  assign rd_data = bank_rd[rd_bank_q];

  // the allocator must keep port 1 off port 0's bank
  a_no_bank_clash: assert property (@(posedge clk) disable iff (rst)
    !(pw0_en && pw1_en && pw0_bank == pw1_bank));

endmodule

`default_nettype wire

//--- hw/bank_mapper.sv
`timescale 1ns/1ps
`include "mrnw_config.svh"
`default_nettype none

module bank_mapper (
  input  logic                s1_wr0_en,
  input  logic                s1_wr1_en,
  input  mrnw_pkg::vbank_t    s1_wr0_bank,
  input  mrnw_pkg::vbank_t    s1_wr1_bank,
  input  mrnw_pkg::vbank_t    s1_rd_bank,
  input  mrnw_pkg::vrow_t     s1_wr1_row,
  input  mrnw_pkg::map_row_t  map0,
  input  mrnw_pkg::map_row_t  map1,
  input  mrnw_pkg::map_row_t  map_rd,
  output logic                pw0_en,
  output logic                pw1_en,
  output mrnw_pkg::pbank_t    pw0_bank,
  output mrnw_pkg::pbank_t    pw1_bank,
  output mrnw_pkg::pbank_t    pr_bank,
  output logic                upd_en,
  output mrnw_pkg::vrow_t     upd_row,
  output mrnw_pkg::map_row_t  upd_map
);

  logic [`MRNW_NUM_PBNK-1:0] used_mask;

  // port 0 and the read stay where the map puts them
  assign pw0_en = s1_wr0_en;
  assign pw0_bank = map0[s1_wr0_bank];
  assign pr_bank = map_rd[s1_rd_bank];

  always_comb begin
    used_mask = '0;
    for (int v = 0; v < `MRNW_NUM_VBNK; v++) begin
      if (mrnw_pkg::vbank_t'(v) != s1_wr1_bank) begin
        used_mask[map1[v]] = 1'b1;
      end
    end
    // the other virtual banks of a sound map row sit in distinct banks
    if (s1_wr1_en) begin
      a_map_row_sound: assert ($countones(used_mask) == `MRNW_NUM_VBNK - 1);
    end
    // a bank takes one write per cycle, whatever row port 0 is in
    if (s1_wr0_en) begin
      used_mask[pw0_bank] = 1'b1;
    end
    // downward scan, so the lowest free bank is the last one kept
    pw1_bank = '0;
    for (int p = `MRNW_NUM_PBNK - 1; p >= 0; p--) begin
      if (!used_mask[p]) begin
        pw1_bank = mrnw_pkg::pbank_t'(p);
      end
    end
    upd_map = map1;
    upd_map[s1_wr1_bank] = pw1_bank;
  end

  assign pw1_en = s1_wr1_en;
  assign upd_en = s1_wr1_en;
  assign upd_row = s1_wr1_row;

endmodule

`default_nettype wire

//--- hw/map_table.sv
`timescale 1ns/1ps
`include "mrnw_config.svh"
`default_nettype none

module map_table (
  input  logic                clk,
  input  logic                rst,
  input  mrnw_pkg::vrow_t     lk_row0,
  input  mrnw_pkg::vrow_t     lk_row1,
  input  mrnw_pkg::vrow_t     lk_row_rd,
  input  logic                upd_en,
  input  mrnw_pkg::vrow_t     upd_row,
  input  mrnw_pkg::map_row_t  upd_map,
  output mrnw_pkg::map_row_t  map0,
  output mrnw_pkg::map_row_t  map1,
  output mrnw_pkg::map_row_t  map_rd,
  output logic                ready
);

  logic [`MRNW_VROW_W:0]          init_row;
  logic                           init_busy;
  mrnw_pkg::map_row_t             ident_row;
  logic                           map_we;
  mrnw_pkg::vrow_t                map_waddr;
  mrnw_pkg::map_row_t             map_wdata;
  mrnw_pkg::map_row_t [2:0]       map_rdata;
  mrnw_pkg::vrow_t                lk_row0_q;
  mrnw_pkg::vrow_t                lk_row1_q;
  mrnw_pkg::vrow_t                lk_row_rd_q;
  logic                           fwd_vld;
  mrnw_pkg::vrow_t                fwd_row;
  mrnw_pkg::map_row_t             fwd_map;

  // row counter walks every row once after reset, msb set means done
  assign init_busy = !init_row[`MRNW_VROW_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      init_row <= '0;
      ready <= 1'b0;
    end else begin
      if (init_busy) begin
        init_row <= init_row + 1'b1;
      end
      ready <= !init_busy;
    end
  end

  // virtual bank v starts out in physical bank v, the last bank is spare
  always_comb begin
    for (int v = 0; v < `MRNW_NUM_VBNK; v++) begin
      ident_row[v] = mrnw_pkg::pbank_t'(v);
    end
  end

  assign map_we = init_busy || upd_en;
  assign map_waddr = init_busy ? init_row[`MRNW_VROW_W-1:0] : upd_row;
  assign map_wdata = init_busy ? ident_row : upd_map;

  sram_multi_read #(
    .word_t (mrnw_pkg::map_row_t),
    .DEPTH  (`MRNW_NUM_VROW),
    .NUM_RD (3)
  ) u_map_mem (
    .clk   (clk),
    .we    (map_we),
    .waddr (map_waddr),
    .wdata (map_wdata),
    .raddr ({lk_row_rd, lk_row1, lk_row0}),
    .rdata (map_rdata)
  );

  // the write of the lookup cycle misses the memory read, keep it for one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_vld <= 1'b0;
    end else begin
      fwd_vld <= map_we;
    end
  end

  always_ff @(posedge clk) begin
    fwd_row <= map_waddr;
    fwd_map <= map_wdata;
    lk_row0_q <= lk_row0;
    lk_row1_q <= lk_row1;
    lk_row_rd_q <= lk_row_rd;
  end

  assign map0 = (fwd_vld && fwd_row == lk_row0_q) ? fwd_map : map_rdata[0];
  assign map1 = (fwd_vld && fwd_row == lk_row1_q) ? fwd_map : map_rdata[1];
  assign map_rd = (fwd_vld && fwd_row == lk_row_rd_q) ? fwd_map : map_rdata[2];

  // map updates come from accepted requests, which need ready
  a_upd_after_ready: assert property (@(posedge clk) disable iff (rst) upd_en |-> ready);

endmodule

`default_nettype wire

//--- hw/mrnw_config.svh
`ifndef MRNW_CONFIG_SVH
`define MRNW_CONFIG_SVH

// data word width
`define MRNW_DATA_W 16

// bank counts, one spare physical bank for relocation
`define MRNW_NUM_VBNK 4
`define MRNW_NUM_PBNK 5

// rows per bank
`define MRNW_NUM_VROW 16

// index widths
`define MRNW_VBNK_W 2
`define MRNW_PBNK_W 3
`define MRNW_VROW_W 4
`define MRNW_ADDR_W (`MRNW_VBNK_W + `MRNW_VROW_W)

`endif

//--- hw/mrnw_core.sv
`timescale 1ns/1ps
`default_nettype none

// two write ports, one read port, built from single-write banks
module mrnw_core (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr0_en,
  input  mrnw_pkg::addr_t  wr0_addr,
  input  mrnw_pkg::data_t  wr0_data,
  input  logic             wr1_en,
  input  mrnw_pkg::addr_t  wr1_addr,
  input  mrnw_pkg::data_t  wr1_data,
  input  logic             rd_en,
  input  mrnw_pkg::addr_t  rd_addr,
  output logic             rd_vld,
  output mrnw_pkg::data_t  rd_data,
  output logic             ready
);

  mrnw_pkg::vrow_t    lk_row0;
  mrnw_pkg::vrow_t    lk_row1;
  mrnw_pkg::vrow_t    lk_row_rd;
  logic               s1_wr0_en;
  logic               s1_wr1_en;
  logic               s1_rd_en;
  mrnw_pkg::vbank_t   s1_wr0_bank;
  mrnw_pkg::vbank_t   s1_wr1_bank;
  mrnw_pkg::vbank_t   s1_rd_bank;
  mrnw_pkg::vrow_t    s1_wr0_row;
  mrnw_pkg::vrow_t    s1_wr1_row;
  mrnw_pkg::vrow_t    s1_rd_row;
  mrnw_pkg::data_t    s1_wr0_data;
  mrnw_pkg::data_t    s1_wr1_data;
  mrnw_pkg::map_row_t map0;
  mrnw_pkg::map_row_t map1;
  mrnw_pkg::map_row_t map_rd;
  logic               pw0_en;
  logic               pw1_en;
  mrnw_pkg::pbank_t   pw0_bank;
  mrnw_pkg::pbank_t   pw1_bank;
  mrnw_pkg::pbank_t   pr_bank;
  logic               upd_en;
  mrnw_pkg::vrow_t    upd_row;
  mrnw_pkg::map_row_t upd_map;

  // stage 0 accept and lookup, stage 1 map and bank write
  req_pipe u_req_pipe (
    .clk (clk), .rst (rst), .ready (ready),
    .wr0_en (wr0_en), .wr0_addr (wr0_addr), .wr0_data (wr0_data),
    .wr1_en (wr1_en), .wr1_addr (wr1_addr), .wr1_data (wr1_data),
    .rd_en (rd_en), .rd_addr (rd_addr),
    .lk_row0 (lk_row0), .lk_row1 (lk_row1), .lk_row_rd (lk_row_rd),
    .s1_wr0_en (s1_wr0_en), .s1_wr1_en (s1_wr1_en), .s1_rd_en (s1_rd_en),
    .s1_wr0_bank (s1_wr0_bank), .s1_wr1_bank (s1_wr1_bank), .s1_rd_bank (s1_rd_bank),
    .s1_wr0_row (s1_wr0_row), .s1_wr1_row (s1_wr1_row), .s1_rd_row (s1_rd_row),
    .s1_wr0_data (s1_wr0_data), .s1_wr1_data (s1_wr1_data)
  );

  map_table u_map_table (
    .clk (clk), .rst (rst),
    .lk_row0 (lk_row0), .lk_row1 (lk_row1), .lk_row_rd (lk_row_rd),
    .upd_en (upd_en), .upd_row (upd_row), .upd_map (upd_map),
    .map0 (map0), .map1 (map1), .map_rd (map_rd), .ready (ready)
  );

  bank_mapper u_bank_mapper (
    .s1_wr0_en (s1_wr0_en), .s1_wr1_en (s1_wr1_en),
    .s1_wr0_bank (s1_wr0_bank), .s1_wr1_bank (s1_wr1_bank), .s1_rd_bank (s1_rd_bank),
    .s1_wr1_row (s1_wr1_row), .map0 (map0), .map1 (map1), .map_rd (map_rd),
    .pw0_en (pw0_en), .pw1_en (pw1_en),
    .pw0_bank (pw0_bank), .pw1_bank (pw1_bank), .pr_bank (pr_bank),
    .upd_en (upd_en), .upd_row (upd_row), .upd_map (upd_map)
  );

  bank_array u_bank_array (
    .clk (clk), .rst (rst),
    .pw0_en (pw0_en), .pw1_en (pw1_en), .pw0_bank (pw0_bank), .pw1_bank (pw1_bank),
    .s1_wr0_row (s1_wr0_row), .s1_wr1_row (s1_wr1_row),
    .s1_wr0_data (s1_wr0_data), .s1_wr1_data (s1_wr1_data),
    .s1_rd_en (s1_rd_en), .pr_bank (pr_bank), .s1_rd_row (s1_rd_row),
    .rd_vld (rd_vld), .rd_data (rd_data)
  );

endmodule

`default_nettype wire

//--- hw/mrnw_pkg.sv
`include "mrnw_config.svh"
`default_nettype none

package mrnw_pkg;

  // one data word as stored in a bank
  typedef logic [`MRNW_DATA_W-1:0] data_t;

  // full address, virtual bank in the low bits
  typedef logic [`MRNW_ADDR_W-1:0] addr_t;

  typedef logic [`MRNW_VBNK_W-1:0] vbank_t;
  typedef logic [`MRNW_PBNK_W-1:0] pbank_t;
  typedef logic [`MRNW_VROW_W-1:0] vrow_t;

  // physical bank per virtual bank, entry v holds the bank of virtual bank v
  typedef pbank_t [`MRNW_NUM_VBNK-1:0] map_row_t;

endpackage

`default_nettype wire

//--- hw/req_pipe.sv
`timescale 1ns/1ps
`include "mrnw_config.svh"
`default_nettype none

module req_pipe (
  input  logic              clk,
  input  logic              rst,
  input  logic              ready,
  input  logic              wr0_en,
  input  mrnw_pkg::addr_t   wr0_addr,
  input  mrnw_pkg::data_t   wr0_data,
  input  logic              wr1_en,
  input  mrnw_pkg::addr_t   wr1_addr,
  input  mrnw_pkg::data_t   wr1_data,
  input  logic              rd_en,
  input  mrnw_pkg::addr_t   rd_addr,
  output mrnw_pkg::vrow_t   lk_row0,
  output mrnw_pkg::vrow_t   lk_row1,
  output mrnw_pkg::vrow_t   lk_row_rd,
  output logic              s1_wr0_en,
  output logic              s1_wr1_en,
  output logic              s1_rd_en,
  output mrnw_pkg::vbank_t  s1_wr0_bank,
  output mrnw_pkg::vbank_t  s1_wr1_bank,
  output mrnw_pkg::vbank_t  s1_rd_bank,
  output mrnw_pkg::vrow_t   s1_wr0_row,
  output mrnw_pkg::vrow_t   s1_wr1_row,
  output mrnw_pkg::vrow_t   s1_rd_row,
  output mrnw_pkg::data_t   s1_wr0_data,
  output mrnw_pkg::data_t   s1_wr1_data
);

  logic wr0_acc;
  logic wr1_acc;
  logic rd_acc;

  // requests before ready are dropped, port 1 wins a same-address write
  assign wr1_acc = wr1_en && ready;
  assign wr0_acc = wr0_en && ready && !(wr1_acc && wr1_addr == wr0_addr);
  assign rd_acc = rd_en && ready;

  // low bits pick the virtual bank, so consecutive addresses spread out
  assign lk_row0 = wr0_addr[`MRNW_ADDR_W-1:`MRNW_VBNK_W];
  assign lk_row1 = wr1_addr[`MRNW_ADDR_W-1:`MRNW_VBNK_W];
  assign lk_row_rd = rd_addr[`MRNW_ADDR_W-1:`MRNW_VBNK_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_wr0_en <= 1'b0;
      s1_wr1_en <= 1'b0;
      s1_rd_en <= 1'b0;
    end else begin
      s1_wr0_en <= wr0_acc;
      s1_wr1_en <= wr1_acc;
      s1_rd_en <= rd_acc;
    end
  end

  always_ff @(posedge clk) begin
    s1_wr0_bank <= wr0_addr[`MRNW_VBNK_W-1:0];
    s1_wr1_bank <= wr1_addr[`MRNW_VBNK_W-1:0];
    s1_rd_bank <= rd_addr[`MRNW_VBNK_W-1:0];
    s1_wr0_row <= lk_row0;
    s1_wr1_row <= lk_row1;
    s1_rd_row <= lk_row_rd;
    s1_wr0_data <= wr0_data;
    s1_wr1_data <= wr1_data;
  end

endmodule

`default_nettype wire

//--- hw/sram_multi_read.sv
`timescale 1ns/1ps
`default_nettype none

// one write port, NUM_RD read ports, all reads registered
module sram_multi_read #(
  parameter type word_t = logic [7:0],
  parameter int DEPTH = 16,
  parameter int NUM_RD = 1
) (
  input  logic                                   clk,
  input  logic                                   we,
  input  logic [$clog2(DEPTH)-1:0]               waddr,
  input  word_t                                  wdata,
  input  logic [NUM_RD-1:0][$clog2(DEPTH)-1:0]   raddr,
  output word_t [NUM_RD-1:0]                     rdata
);

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // a read in the same cycle as a write to that word sees the old word
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_RD; i++) begin
      rdata[i] <= mem[raddr[i]];
    end
  end

endmodule

`default_nettype wire

//--- testbench/mrnw_vectors.txt
# wr0_en wr0_addr wr0_data wr1_en wr1_addr wr1_data rd_en rd_addr expected_rd_data
# one line per cycle, hex, address is {row, virtual bank}, expected used when rd_en is 1
1 0c 1111 0 00 0000 0 00 0000
0 00 0000 0 00 0000 1 0c 1111
0 00 0000 1 0d 2222 0 00 0000
1 0e 3333 1 0f 4444 1 0d 2222
1 0d 5555 1 0c 6666 1 0f 4444
0 00 0000 1 0e 7777 1 0c 6666
1 0f 8888 1 0d 9999 1 0e 7777
0 00 0000 0 00 0000 1 0d 9999
0 00 0000 0 00 0000 1 0f 8888
0 00 0000 0 00 0000 1 0c 6666
0 00 0000 0 00 0000 1 0e 7777
1 14 aaaa 1 14 bbbb 0 00 0000
0 00 0000 0 00 0000 1 14 bbbb
1 15 cccc 1 15 dddd 1 14 bbbb
0 00 0000 0 00 0000 1 15 dddd
1 16 1234 0 00 0000 0 00 0000
1 16 5678 0 00 0000 1 16 1234
0 00 0000 0 00 0000 1 16 5678
0 00 0000 1 16 9abc 1 16 5678
0 00 0000 0 00 0000 1 16 9abc
1 17 0f0f 1 0c f0f0 1 15 dddd
1 0c 1357 1 17 2468 1 0c f0f0
0 00 0000 0 00 0000 1 0c 1357
0 00 0000 0 00 0000 1 17 2468
1 00 aa55 1 3f 55aa 1 17 2468
1 3f 0001 1 00 0002 1 00 aa55
0 00 0000 0 00 0000 1 3f 0001
0 00 0000 0 00 0000 1 00 0002

//--- testbench/tb_mrnw_core.sv
`timescale 1ns/1ps
`include "mrnw_config.svh"
`default_nettype none

module tb_mrnw_core;

  localparam int RAND_CYCLES = 400;
  localparam int MARGIN = 50;
  localparam int MAX_VEC = 64;
  localparam int NUM_ADDR = 1 << `MRNW_ADDR_W;
  localparam int DW = `MRNW_DATA_W;

  logic            clk;
  logic            rst;
  logic            wr0_en;
  mrnw_pkg::addr_t wr0_addr;
  mrnw_pkg::data_t wr0_data;
  logic            wr1_en;
  mrnw_pkg::addr_t wr1_addr;
  mrnw_pkg::data_t wr1_data;
  logic            rd_en;
  mrnw_pkg::addr_t rd_addr;
  logic            rd_vld;
  mrnw_pkg::data_t rd_data;
  logic            ready;

  // raw fields of each vector line
  logic [31:0]     vec [MAX_VEC][9];
  int              n_vec;
  int              cycles = 0;
  int              cycle_limit;
  logic            ready_seen;
  mrnw_pkg::data_t shadow_mem [NUM_ADDR];
  logic            shadow_known [NUM_ADDR];
  // each entry is {rd_vld, compare data, data}
  logic [DW+1:0]   exp_q [$];

  mrnw_core DUT (
    .clk (clk), .rst (rst),
    .wr0_en (wr0_en), .wr0_addr (wr0_addr), .wr0_data (wr0_data),
    .wr1_en (wr1_en), .wr1_addr (wr1_addr), .wr1_data (wr1_data),
    .rd_en (rd_en), .rd_addr (rd_addr),
    .rd_vld (rd_vld), .rd_data (rd_data), .ready (ready)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: the run went past its limit of %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [9];
    fd = $fopen("testbench/mrnw_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/mrnw_vectors.txt");
      $display("*** FAILED ***");
      $fatal(1, "no vector file");
    end else begin
      n_vec = 0;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        cnt = 0;
        if (line.len() > 0 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        end
        if (cnt == 9 && n_vec < MAX_VEC) begin
          for (int k = 0; k < 9; k++) begin
            vec[n_vec][k] = f[k];
          end
          n_vec++;
        end
      end
      $fclose(fd);
    end
  endtask

  // response of the read driven two falling edges ago
  task automatic check_response();
    logic [DW+1:0] ent;
    if (exp_q.size() == 2) begin
      ent = exp_q.pop_front();
      check_value("rd_vld", 32'(rd_vld), 32'(ent[DW+1]));
      if (ent[DW]) begin
        check_value("rd_data", 32'(rd_data), 32'(ent[DW-1:0]));
      end
    end
  endtask

  // called on a falling edge, a request counts only if ready is high now
  task automatic drive_cycle(input logic w0e, input mrnw_pkg::addr_t w0a,
                             input mrnw_pkg::data_t w0d, input logic w1e,
                             input mrnw_pkg::addr_t w1a, input mrnw_pkg::data_t w1d,
                             input logic re, input mrnw_pkg::addr_t ra,
                             input logic chk, input mrnw_pkg::data_t exp_data);
    logic acc;
    check_response();
    if (ready_seen) begin
      check_value("ready", 32'(ready), 32'd1);
    end
    acc = ready;
    wr0_en = w0e;
    wr0_addr = w0a;
    wr0_data = w0d;
    wr1_en = w1e;
    wr1_addr = w1a;
    wr1_data = w1d;
    rd_en = re;
    rd_addr = ra;
    exp_q.push_back({re && acc, chk && re && acc, exp_data});
    // port 1 goes second so it wins a shared address
    if (acc && w0e) begin
      shadow_mem[w0a] = w0d;
      shadow_known[w0a] = 1'b1;
    end
    if (acc && w1e) begin
      shadow_mem[w1a] = w1d;
      shadow_known[w1a] = 1'b1;
    end
  endtask

  function automatic mrnw_pkg::addr_t pick_addr();
    logic [31:0]     rnd;
    mrnw_pkg::addr_t a;
    rnd = $urandom;
    a = rnd[`MRNW_ADDR_W-1:0];
    // half the traffic stays in rows 0 and 1 so banks keep moving
    if (rnd[31]) begin
      a[`MRNW_ADDR_W-1:`MRNW_VBNK_W+1] = '0;
    end
    return a;
  endfunction

  task automatic run_random();
    logic [31:0]     rnd;
    logic            w0e;
    logic            w1e;
    logic            re;
    mrnw_pkg::addr_t w0a;
    mrnw_pkg::addr_t w1a;
    mrnw_pkg::addr_t ra;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      rnd = $urandom;
      w0e = rnd[1:0] != 2'b00;
      w1e = rnd[3:2] != 2'b00;
      re = rnd[5:4] != 2'b00;
      w0a = pick_addr();
      w1a = pick_addr();
      ra = pick_addr();
      rnd = $urandom;
      drive_cycle(w0e, w0a, rnd[DW-1:0], w1e, w1a, rnd[31:32-DW], re, ra,
                  shadow_known[ra], shadow_mem[ra]);
      @(negedge clk);
    end
  endtask

  initial begin
    int wait_cnt;
    clk = 1'b0;
    rst = 1'b1;
    wr0_en = 1'b0;
    wr0_addr = '0;
    wr0_data = '0;
    wr1_en = 1'b0;
    wr1_addr = '0;
    wr1_data = '0;
    rd_en = 1'b0;
    rd_addr = '0;
    ready_seen = 1'b0;
    void'($urandom(80371));
    for (int a = 0; a < NUM_ADDR; a++) begin
      shadow_known[a] = 1'b0;
    end
    load_vectors();
    cycle_limit = 2 + `MRNW_NUM_VROW + 2 + n_vec + RAND_CYCLES + 2 + MARGIN;

    repeat (2) @(negedge clk);
    check_value("ready", 32'(ready), 32'd0);
    check_value("rd_vld", 32'(rd_vld), 32'd0);
    rst = 1'b0;

    // requests while ready is low must be dropped
    wait_cnt = 0;
    while (!ready) begin
      if (wait_cnt > `MRNW_NUM_VROW + 2) begin
        $display("ready stayed low for more than %0d cycles", `MRNW_NUM_VROW + 2);
        $display("*** FAILED ***");
        $fatal(1, "ready stuck low");
      end else begin
        drive_cycle(1'b1, 6'h05, 16'hdead, 1'b1, 6'h09, 16'hbeef,
                    1'b1, 6'h05, 1'b0, 16'h0000);
        @(negedge clk);
        wait_cnt++;
      end
    end
    ready_seen = 1'b1;

    for (int i = 0; i < n_vec; i++) begin
      drive_cycle(vec[i][0][0], vec[i][1][`MRNW_ADDR_W-1:0], vec[i][2][DW-1:0],
                  vec[i][3][0], vec[i][4][`MRNW_ADDR_W-1:0], vec[i][5][DW-1:0],
                  vec[i][6][0], vec[i][7][`MRNW_ADDR_W-1:0],
                  vec[i][6][0], vec[i][8][DW-1:0]);
      @(negedge clk);
    end

    run_random();

    // let the last reads come back
    repeat (2) begin
      drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
      @(negedge clk);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
